// File: williams2_front.f
+incdir+hdl
hdl/williams2_pkg.sv
hdl/dl_bus_if.sv
hdl/rom_loader.sv
hdl/boot_reset.sv
hdl/button_stretch.sv
hdl/gun_tracker.sv
hdl/control_mapper.sv
hdl/williams2_front.sv
verif/tb_williams2_front.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and fail if the log reports a failure
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module tb_williams2_front -f williams2_front.f \
	-o tb_williams2_front > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_williams2_front > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: verif/tb_williams2_front.sv
/* Random testbench for the control front end with a seeded stimulus and a local model.
   The stretch test alone runs about a million cycles */
`timescale 1ns/10ps
`include "williams2_params.svh"

module tb_williams2_front;
	import williams2_pkg::*;

	localparam longint RUN_CYCLES = 16 + 300 * 8 + 40 + 4 * 200 + 150 * 2
	                                + `W2_STRETCH_CYCLES + 20;

	logic         clk_mem;
	logic         rst_n_i;
	game_e        game_i;
	logic         user_reset_i;
	logic         dl_active_i;
	logic         dl_valid_i;
	logic [7:0]   dl_index_i;
	dl_addr_t     dl_addr_i;
	dl_byte_t     dl_data_i;
	logic         dl_ready_o;
	logic         mem_ready_i;
	logic         mem_valid_o;
	logic         mem_gfx_o;
	mem_addr_t    mem_addr_o;
	mem_be_t      mem_be_o;
	mem_word_t    mem_data_o;
	logic         core_reset_o;
	logic         adv_btn_i;
	logic         hsr_btn_i;
	logic         advance_o;
	logic         hs_reset_o;
	player_t      p1_i;
	player_t      p2_i;
	logic         start1_i;
	logic         start2_i;
	logic         mouse_strobe_i;
	mouse_delta_t mouse_dx_i;
	mouse_delta_t mouse_dy_i;
	logic [2:0]   mouse_btn_i;
	logic         input_sel_i;
	in_port_t     in1_o;
	in_port_t     in2_o;

	integer      seed = 11141;
	int          err_val;
	int          err_hs;
	logic [41:0] mq[$]; // Expected requests {gfx, addr, be, data}
	logic [8:0]  acc_h;
	logic [8:0]  acc_v;

	williams2_front dut0 (.*);

	initial begin
		clk_mem = 1'b0;
		forever #4 clk_mem = ~clk_mem;
	end

	initial begin
		#(RUN_CYCLES * 16); // Twice the expected run at 8 ns per cycle
		$display("Watchdog expired before all tests completed");
		$display("TB FAILED");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
	                               input logic [63:0] act_v);
		err_val++;
		$display("error %s: expected %0h actual %0h", name, exp_v, act_v);
	endtask

	function automatic logic [5:0] gray6(input logic [8:0] acc);
		return acc[8:3] ^ (acc[8:3] >> 1);
	endfunction

	// Player bits from the top: up, down, left, right, fire A..E, up2, down2, left2, right2
	function automatic logic [15:0] expect_ports(input logic [1:0] g, input logic [13:0] a,
	                                             input logic [13:0] b, input logic s1,
	                                             input logic s2, input logic [2:0] mb,
	                                             input logic sel, input logic [5:0] gun);
		logic [13:0] p;
		logic [7:0]  i1;
		logic [7:0]  i2;
		p = sel ? b : a;
		i1 = 8'h00;
		i2 = 8'h00;
		case (g)
			2'd0: begin
				i1 = {~(a[9] | b[9] | mb[0]), 1'b0, gun};
				i2 = {s2, s1, 4'b0000, a[7] | b[7] | mb[2], a[8] | b[8] | mb[1]};
			end
			2'd1: i1 = {2'b11, ~a[8], ~b[8], ~{1'b0, p[9], p[10], p[11]}};
			2'd2: begin
				i1 = ~{p[3] | p[5], p[1] | p[6], p[2] | p[7], p[4] | p[8],
				       p[12], p[10], p[11], p[13]};
				i2 = {s2, s1, 4'b0000, b[9], a[9]};
			end
			default: i1 = {a[9], 1'b0, s2, s1, a[11], a[12], a[10], a[13]};
		endcase
		return {i1, i2};
	endfunction

	// Checks one cycle of the request port, then advances the queue model
	task automatic step_memory();
		logic [41:0] got;
		logic [24:0] a;
		logic        gfx;
		#1;
		got = {mem_gfx_o, mem_addr_o, mem_be_o, mem_data_o};
		if (dl_active_i && core_reset_o !== 1'b1)
			report_mismatch("download core_reset_o", 1, core_reset_o);
		if (mem_valid_o !== (mq.size() != 0))
			report_mismatch("download mem_valid_o", mq.size() != 0, mem_valid_o);
		else if (mem_valid_o && got !== mq[0])
			report_mismatch("download request", mq[0], got);
		if (dl_ready_o !== (mq.size() == 0 || mem_ready_i))
			report_mismatch("download dl_ready_o", mq.size() == 0 || mem_ready_i, dl_ready_o);
		if (mem_valid_o && mem_ready_i && mq.size() != 0)
			void'(mq.pop_front());
		if (dl_valid_i && dl_ready_o && dl_index_i == 8'd0) begin
			a = dl_addr_i;
			gfx = (a >= `W2_GFX_BASE);
			if (gfx)
				a = a - `W2_GFX_BASE;
			mq.push_back({gfx, a[23:1], a[0] ? 2'b10 : 2'b01, dl_data_i, dl_data_i});
		end
	endtask

	initial begin
		int          sent;
		int          stall;
		int          offs;
		int          highs;
		bit          pend;
		logic [15:0] exp_ports;
		rst_n_i = 1'b0;
		game_i = game_tshoot;
		user_reset_i = 1'b0;
		dl_active_i = 1'b0;
		dl_valid_i = 1'b0;
		dl_index_i = 8'd0;
		dl_addr_i = '0;
		dl_data_i = '0;
		mem_ready_i = 1'b0;
		adv_btn_i = 1'b0;
		hsr_btn_i = 1'b0;
		p1_i = '0;
		p2_i = '0;
		start1_i = 1'b0;
		start2_i = 1'b0;
		mouse_strobe_i = 1'b0;
		mouse_dx_i = '0;
		mouse_dy_i = '0;
		mouse_btn_i = 3'b000;
		input_sel_i = 1'b0;
		err_val = 0;
		err_hs = 0;
		acc_h = '0;
		acc_v = '0;
		repeat (16) @(negedge clk_mem);

		// State right after reset
		if (core_reset_o !== 1'b1) report_mismatch("reset core_reset_o", 1, core_reset_o);
		if (mem_valid_o !== 1'b0) report_mismatch("reset mem_valid_o", 0, mem_valid_o);
		if (advance_o !== 1'b0) report_mismatch("reset advance_o", 0, advance_o);
		if (hs_reset_o !== 1'b0) report_mismatch("reset hs_reset_o", 0, hs_reset_o);
		rst_n_i = 1'b1;
		dl_active_i = 1'b1;

		// Download routing with random back-pressure
		sent = 0;
		stall = 0;
		pend = 1'b0;
		while (sent < 300 && stall <= 50) begin
			@(negedge clk_mem);
			mem_ready_i = 1'($random(seed));
			if (!pend) begin
				dl_valid_i = ($random(seed) & 3) != 0; // Idle about a quarter of the time
				dl_index_i = 1'($random(seed)) ? 8'd0 : 8'($random(seed));
				offs = $random(seed) % 131072;
				dl_addr_i = 25'(`W2_GFX_BASE + offs);
				dl_data_i = 8'($random(seed));
				pend = dl_valid_i;
			end
			step_memory();
			if (pend && dl_ready_o) begin
				pend = 1'b0;
				sent++;
				stall = 0;
			end else if (pend) begin
				stall++;
			end
		end
		if (stall > 50) begin
			err_hs++;
			$display("Download write was not accepted within 50 cycles");
		end
		repeat (4) begin
			@(negedge clk_mem);
			dl_valid_i = 1'b0;
			mem_ready_i = 1'b1;
			step_memory();
		end
		if (mq.size() != 0) begin
			err_hs++;
			$display("Memory request still pending after the download drained");
		end

		// Boot reset release and user reset
		@(negedge clk_mem);
		dl_active_i = 1'b0;
		@(negedge clk_mem);
		if (core_reset_o !== 1'b1) report_mismatch("boot core_reset_o", 1, core_reset_o);
		@(negedge clk_mem);
		if (core_reset_o !== 1'b0) report_mismatch("boot core_reset_o", 0, core_reset_o);
		user_reset_i = 1'b1;
		@(negedge clk_mem);
		if (core_reset_o !== 1'b1) report_mismatch("user core_reset_o", 1, core_reset_o);
		user_reset_i = 1'b0;
		@(negedge clk_mem);
		if (core_reset_o !== 1'b0) report_mismatch("user core_reset_o", 0, core_reset_o);

		// Input mapping for every game
		for (int g = 0; g < 4; g++) begin
			for (int n = 0; n < 200; n++) begin
				game_i = game_e'(g);
				p1_i = 14'($random(seed));
				p2_i = 14'($random(seed));
				start1_i = 1'($random(seed));
				start2_i = 1'($random(seed));
				mouse_btn_i = 3'($random(seed));
				input_sel_i = 1'($random(seed));
				@(negedge clk_mem);
				exp_ports = expect_ports(game_i, p1_i, p2_i, start1_i, start2_i, mouse_btn_i,
				                         input_sel_i, gray6(input_sel_i ? acc_h : acc_v));
				if (in1_o !== exp_ports[15:8]) report_mismatch("map in1_o", exp_ports[15:8], in1_o);
				if (in2_o !== exp_ports[7:0]) report_mismatch("map in2_o", exp_ports[7:0], in2_o);
			end
		end

		// Gun tracking under Turkey Shoot
		game_i = game_tshoot;
		for (int n = 0; n < 150; n++) begin
			mouse_strobe_i = 1'b1;
			mouse_dx_i = 9'($random(seed));
			mouse_dy_i = 9'($random(seed));
			input_sel_i = 1'($random(seed));
			acc_h = acc_h + mouse_dx_i;
			acc_v = acc_v - mouse_dy_i; // Vertical axis counts upward
			@(negedge clk_mem);
			mouse_strobe_i = 1'b0;
			@(negedge clk_mem);
			if (in1_o[5:0] !== gray6(input_sel_i ? acc_h : acc_v))
				report_mismatch("gun code", gray6(input_sel_i ? acc_h : acc_v), in1_o[5:0]);
		end

		// Advance button stretch
		adv_btn_i = 1'b1;
		highs = 0;
		stall = 0;
		while (!advance_o && stall < 4) begin
			@(negedge clk_mem);
			stall++;
		end
		if (!advance_o) begin
			err_hs++;
			$display("advance_o did not rise after the button press");
		end
		while (advance_o && highs <= `W2_STRETCH_CYCLES) begin
			if (hs_reset_o !== 1'b0) report_mismatch("stretch hs_reset_o", 0, hs_reset_o);
			highs++;
			@(negedge clk_mem);
			if (highs == 3)
				adv_btn_i = 1'b0;
		end
		if (highs != `W2_STRETCH_CYCLES)
			report_mismatch("stretch length", `W2_STRETCH_CYCLES, highs);

		$display("Done: %0d value errors, %0d handshake errors", err_val, err_hs);
		if (err_val + err_hs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: hdl/williams2_front.sv
/* Control front end for a four-game arcade board, single clock domain.
   Player vectors arrive already decoded; no rotation or swap is done here */
`timescale 1ns/10ps

module williams2_front (
	input  logic                     clk_mem,
	input  logic                     rst_n_i,
	input  williams2_pkg::game_e     game_i,
	input  logic                     user_reset_i,
	input  logic                     dl_active_i,
	input  logic                     dl_valid_i,
	input  logic [7:0]               dl_index_i,
	input  williams2_pkg::dl_addr_t  dl_addr_i,
	input  williams2_pkg::dl_byte_t  dl_data_i,
	output logic                     dl_ready_o,
	input  logic                     mem_ready_i,
	output logic                     mem_valid_o,
	output logic                     mem_gfx_o,
	output williams2_pkg::mem_addr_t mem_addr_o,
	output williams2_pkg::mem_be_t   mem_be_o,
	output williams2_pkg::mem_word_t mem_data_o,
	output logic                     core_reset_o,
	input  logic                     adv_btn_i,
	input  logic                     hsr_btn_i,
	output logic                     advance_o,
	output logic                     hs_reset_o,
	input  williams2_pkg::player_t   p1_i,
	input  williams2_pkg::player_t   p2_i,
	input  logic                     start1_i,
	input  logic                     start2_i,
	input  logic                     mouse_strobe_i,
	input  williams2_pkg::mouse_delta_t mouse_dx_i,
	input  williams2_pkg::mouse_delta_t mouse_dy_i,
	input  logic [2:0]               mouse_btn_i,
	input  logic                     input_sel_i,
	output williams2_pkg::in_port_t  in1_o,
	output williams2_pkg::in_port_t  in2_o
);
	import williams2_pkg::*;

	gun_code_t gun_gray;

	dl_bus_if dl_bus ();

	assign dl_bus.dl_valid  = dl_valid_i;
	assign dl_bus.dl_index  = dl_index_i;
	assign dl_bus.dl_addr   = dl_addr_i;
	assign dl_bus.dl_data   = dl_data_i;
	assign dl_bus.dl_active = dl_active_i;
	assign dl_ready_o       = dl_bus.dl_ready;

	rom_loader rom_loader0 (
		.clk_mem     (clk_mem),
		.rst_n_i     (rst_n_i),
		.dl          (dl_bus.sink),
		.mem_ready_i (mem_ready_i),
		.mem_valid_o (mem_valid_o),
		.mem_gfx_o   (mem_gfx_o),
		.mem_addr_o  (mem_addr_o),
		.mem_be_o    (mem_be_o),
		.mem_data_o  (mem_data_o)
	);

	boot_reset boot_reset0 (
		.clk_mem      (clk_mem),
		.rst_n_i      (rst_n_i),
		.dl           (dl_bus.mon),
		.user_reset_i (user_reset_i),
		.core_reset_o (core_reset_o)
	);

	button_stretch adv_stretch (
		.clk_mem (clk_mem),
		.rst_n_i (rst_n_i),
		.btn_i   (adv_btn_i),
		.pulse_o (advance_o)
	);

	button_stretch hsr_stretch (
		.clk_mem (clk_mem),
		.rst_n_i (rst_n_i),
		.btn_i   (hsr_btn_i),
		.pulse_o (hs_reset_o)
	);

	gun_tracker gun_tracker0 (
		.clk_mem        (clk_mem),
		.rst_n_i        (rst_n_i),
		.mouse_strobe_i (mouse_strobe_i),
		.mouse_dx_i     (mouse_dx_i),
		.mouse_dy_i     (mouse_dy_i),
		.axis_sel_i     (input_sel_i), // Board multiplexes the axes on input_sel
		.gun_gray_o     (gun_gray)
	);

	control_mapper control_mapper0 (
		.game_i      (game_i),
		.p1_i        (p1_i),
		.p2_i        (p2_i),
		.start1_i    (start1_i),
		.start2_i    (start2_i),
		.mouse_btn_i (mouse_btn_i),
		.input_sel_i (input_sel_i),
		.gun_gray_i  (gun_gray),
		.in1_o       (in1_o),
		.in2_o       (in2_o)
	);

endmodule

// File: hdl/control_mapper.sv
/* Builds the two board input ports for the selected game. Purely combinational.
   Several ports are active low on the board, hence the inversions */
`timescale 1ns/10ps

module control_mapper (
	input  williams2_pkg::game_e     game_i,
	input  williams2_pkg::player_t   p1_i,
	input  williams2_pkg::player_t   p2_i,
	input  logic                     start1_i,
	input  logic                     start2_i,
	input  logic [2:0]               mouse_btn_i,
	input  logic                     input_sel_i,
	input  williams2_pkg::gun_code_t gun_gray_i,
	output williams2_pkg::in_port_t  in1_o,
	output williams2_pkg::in_port_t  in2_o
);
	import williams2_pkg::*;

	player_t ps;

	// Player picked by the board's input_sel line
	assign ps = input_sel_i ? p2_i : p1_i;

	always_comb begin
		in1_o = '0;
		in2_o = '0;
		case (game_i)
			game_tshoot: begin
				in1_o = {~(p1_i[PL_FIRE_A] | p2_i[PL_FIRE_A] | mouse_btn_i[0]), 1'b0,
				         gun_gray_i};
				in2_o = {start2_i, start1_i, 4'b0000,
				         p1_i[PL_FIRE_C] | p2_i[PL_FIRE_C] | mouse_btn_i[2],
				         p1_i[PL_FIRE_B] | p2_i[PL_FIRE_B] | mouse_btn_i[1]};
			end
			game_joust2: begin
				in1_o[7:4] = {2'b11, ~p1_i[PL_FIRE_B], ~p2_i[PL_FIRE_B]};
				in1_o[3:0] = ~{1'b0, ps[PL_FIRE_A], ps[PL_RIGHT], ps[PL_LEFT]};
			end
			game_inferno: begin
				// Second stick doubles as fire B to E
				in1_o = ~{ps[PL_DOWN2] | ps[PL_FIRE_E],
				          ps[PL_RIGHT2] | ps[PL_FIRE_D],
				          ps[PL_LEFT2] | ps[PL_FIRE_C],
				          ps[PL_UP2] | ps[PL_FIRE_B],
				          ps[PL_DOWN], ps[PL_RIGHT], ps[PL_LEFT], ps[PL_UP]};
				in2_o = {start2_i, start1_i, 4'b0000, p2_i[PL_FIRE_A], p1_i[PL_FIRE_A]};
			end
			game_mysticm: begin
				in1_o = {p1_i[PL_FIRE_A], 1'b0, start2_i, start1_i,
				         p1_i[PL_LEFT], p1_i[PL_DOWN], p1_i[PL_RIGHT], p1_i[PL_UP]};
			end
			default: begin
				in1_o = '0;
				in2_o = '0;
			end
		endcase
	end

endmodule

// File: hdl/gun_tracker.sv
/* Turkey Shoot gun position from mouse motion. Both axes wrap at 9 bits;
   only the top six bits of the chosen axis leave, as a Gray code */
`timescale 1ns/10ps
`include "williams2_params.svh"

module gun_tracker (
	input  logic                        clk_mem,
	input  logic                        rst_n_i,
	input  logic                        mouse_strobe_i,
	input  williams2_pkg::mouse_delta_t mouse_dx_i,
	input  williams2_pkg::mouse_delta_t mouse_dy_i,
	input  logic                        axis_sel_i,
	output williams2_pkg::gun_code_t    gun_gray_o
);
	import williams2_pkg::*;

	mouse_delta_t acc_h;
	mouse_delta_t acc_v;
	gun_code_t    gun_bin;

	always_ff @(posedge clk_mem) begin
		if (!rst_n_i) begin
			acc_h <= '0;
			acc_v <= '0;
		end else if (mouse_strobe_i) begin
			acc_h <= acc_h + mouse_dx_i;
			acc_v <= acc_v - mouse_dy_i; // Mouse y grows downward
		end
	end

	assign gun_bin = axis_sel_i ? acc_h[`W2_MOUSE_W-1 -: `W2_GUN_W]
	                            : acc_v[`W2_MOUSE_W-1 -: `W2_GUN_W];

	always_ff @(posedge clk_mem) begin
		if (!rst_n_i)
			gun_gray_o <= '0;
		else
			gun_gray_o <= gun_bin ^ (gun_bin >> 1);
	end

endmodule

// File: hdl/button_stretch.sv
/* Turns a rising edge into a pulse HOLD_CYCLES long. A new edge restarts the count */
`timescale 1ns/10ps
`include "williams2_params.svh"

module button_stretch #(
	parameter int HOLD_CYCLES = `W2_STRETCH_CYCLES
) (
	input  logic clk_mem,
	input  logic rst_n_i,
	input  logic btn_i,
	output logic pulse_o
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic             btn_d;
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk_mem) begin
		if (!rst_n_i) begin
			btn_d <= 1'b0;
			count <= '0;
		end else begin
			btn_d <= btn_i;
			if (btn_i && !btn_d)
				count <= CNT_W'(HOLD_CYCLES);
			else if (count != '0)
				count <= count - 1'b1;
		end
	end

	assign pulse_o = (count != '0);

endmodule

// File: hdl/boot_reset.sv
/* Core reset stays high until a download has finished at least once.
   Any download or user request raises it again */
`timescale 1ns/10ps

module boot_reset (
	input  logic   clk_mem,
	input  logic   rst_n_i,
	dl_bus_if.mon  dl,
	input  logic   user_reset_i,
	output logic   core_reset_o
);

	logic dl_active_d;
	logic rom_loaded;

	always_ff @(posedge clk_mem) begin
		if (!rst_n_i) begin
			dl_active_d  <= 1'b0;
			rom_loaded   <= 1'b0;
			core_reset_o <= 1'b1;
		end else begin
			dl_active_d <= dl.dl_active;
			if (dl_active_d && !dl.dl_active)
				rom_loaded <= 1'b1; // End of download
			core_reset_o <= user_reset_i | dl.dl_active | ~rom_loaded;
		end
	end

endmodule

// File: hdl/rom_loader.sv
/* One-entry request buffer between the download stream and the memory controller.
   Writes on other indexes are accepted and dropped. Byte address bit 24 is not stored */
`timescale 1ns/10ps
`include "williams2_params.svh"

module rom_loader (
	input  logic                     clk_mem,
	input  logic                     rst_n_i,
	dl_bus_if.sink                   dl,
	input  logic                     mem_ready_i,
	output logic                     mem_valid_o,
	output logic                     mem_gfx_o,
	output williams2_pkg::mem_addr_t mem_addr_o,
	output williams2_pkg::mem_be_t   mem_be_o,
	output williams2_pkg::mem_word_t mem_data_o
);
	import williams2_pkg::*;

	logic     accept;
	logic     is_rom;
	logic     is_gfx;
	dl_addr_t rebased;

	// Room when empty or when the held request leaves this cycle
	assign dl.dl_ready = ~mem_valid_o | mem_ready_i;
	assign accept      = dl.dl_valid & dl.dl_ready;

	assign is_rom  = (dl.dl_index == `W2_ROM_INDEX);
	assign is_gfx  = (dl.dl_addr >= `W2_GFX_BASE);
	assign rebased = is_gfx ? dl.dl_addr - `W2_GFX_BASE : dl.dl_addr;

	always_ff @(posedge clk_mem) begin
		if (!rst_n_i) begin
			mem_valid_o <= 1'b0;
		end else if (accept) begin
			mem_valid_o <= is_rom;
		end else if (mem_ready_i) begin
			mem_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_mem) begin
		if (accept && is_rom) begin
			mem_gfx_o  <= is_gfx;
			mem_addr_o <= rebased[`W2_MEM_ADDR_W:1]; // Word address
			mem_be_o   <= rebased[0] ? 2'b10 : 2'b01;
			mem_data_o <= {dl.dl_data, dl.dl_data};
		end
	end

endmodule

// File: hdl/dl_bus_if.sv
/* Download write stream. A write moves when dl_valid and dl_ready are both high.
   dl_active is a level that stays high for the whole download */
`timescale 1ns/10ps

interface dl_bus_if;
	import williams2_pkg::*;

	logic     dl_valid;
	logic     dl_ready;
	logic     [7:0] dl_index;
	dl_addr_t dl_addr;
	dl_byte_t dl_data;
	logic     dl_active;

	modport src (
		output dl_valid,
		output dl_index,
		output dl_addr,
		output dl_data,
		output dl_active,
		input  dl_ready
	);

	modport sink (
		input  dl_valid,
		input  dl_index,
		input  dl_addr,
		input  dl_data,
		output dl_ready
	);

	modport mon (
		input  dl_active
	);

endinterface

// File: hdl/williams2_pkg.sv
/* Shared types. player_t bit 0 is spare and ignored by the mapper */
`include "williams2_params.svh"

package williams2_pkg;

	typedef logic [`W2_DL_ADDR_W-1:0]         dl_addr_t;
	typedef logic [7:0]                       dl_byte_t;
	typedef logic [`W2_MEM_ADDR_W-1:0]        mem_addr_t;
	typedef logic [15:0]                      mem_word_t;
	typedef logic [1:0]                       mem_be_t;
	typedef logic signed [`W2_MOUSE_W-1:0]    mouse_delta_t;
	typedef logic [`W2_GUN_W-1:0]             gun_code_t;
	typedef logic [7:0]                       in_port_t;
	typedef logic [13:0]                      player_t;

	typedef enum logic [1:0] {
		game_tshoot,
		game_joust2,
		game_inferno,
		game_mysticm
	} game_e;

	// Bit positions inside player_t
	localparam int PL_UP    = 13;
	localparam int PL_DOWN  = 12;
	localparam int PL_LEFT  = 11;
	localparam int PL_RIGHT = 10;
	localparam int PL_FIRE_A = 9;
	localparam int PL_FIRE_B = 8;
	localparam int PL_FIRE_C = 7;
	localparam int PL_FIRE_D = 6;
	localparam int PL_FIRE_E = 5;
	localparam int PL_UP2    = 4;
	localparam int PL_DOWN2  = 3;
	localparam int PL_LEFT2  = 2;
	localparam int PL_RIGHT2 = 1;

endpackage

// File: hdl/williams2_params.svh
/* Address map and sizes for the front end. The graphics region starts at byte 0x25000
   and everything below it is CPU ROM. Only download index 0 carries the ROM image */
`ifndef WILLIAMS2_PARAMS_SVH
`define WILLIAMS2_PARAMS_SVH

`define W2_DL_ADDR_W      25
`define W2_GFX_BASE       25'h25000
`define W2_MEM_ADDR_W     23
`define W2_ROM_INDEX      8'd0

// Roughly 11 ms at 96 MHz
`define W2_STRETCH_CYCLES 1048575

`define W2_MOUSE_W        9
`define W2_GUN_W          6

`endif
